// ==== sources.f ====
+incdir+.
breakout_pkg.sv
vga_timing.sv
game_control.sv
ball_motion.sv
brick_wall.sv
paddle_motion.sv
pixel_mixer.sv
breakout_top.sv
breakout_assertions.sv
tb_checker.sv
tb_breakout.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_breakout
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failed" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb_breakout.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module tb_breakout;
	import breakout_pkg::*;

	typedef struct packed {
		logic [7:0]  id;
		logic [1:0]  keys;
		logic        start;
		logic [31:0] hold;  // Settle cycles after the condition is met
		logic [31:0] limit; // Timeout in cycles for the condition
		logic [15:0] exp;
	} row_t;

	localparam int NUM_ROWS = 8;

	logic         clk;
	logic         rst;
	logic         start_game;
	logic [1:0]   keys;
	vga_out_t     video;
	game_status_t status;
	logic         check_req;
	logic         timed_out;
	int           test_id;
	logic [15:0]  exp_val;
	int           hs_periods;
	int           centre_seen;
	int           white_seen;
	int           err_count;
	int           tests_run;
	int           tests_failed;
	row_t         rows [NUM_ROWS];
	int           cnt;

	breakout_top #(.BALL_DIV(4), .PADDLE_DIV(3)) dut_i (
		.clk(clk), .rst(rst), .start_game(start_game), .keys(keys),
		.video(video), .status(status)
	);

	tb_checker checker_i (
		.clk(clk), .rst(rst), .keys(keys), .check_req(check_req), .timed_out(timed_out),
		.test_id(test_id), .exp_val(exp_val), .video(video), .status(status),
		.pos(dut_i.timing_i.pos), .hs_periods(hs_periods), .centre_seen(centre_seen),
		.white_seen(white_seen), .err_count(err_count), .tests_run(tests_run),
		.tests_failed(tests_failed)
	);

	always #4 clk = ~clk;

	// Condition that ends the wait phase of a row
	function automatic logic cond_met(input int id, input logic [15:0] exp);
		case (id)
			2: return hs_periods >= int'(exp);
			3, 5: return status.paddle_x == exp[10:0];
			6: return (centre_seen > 0) && (white_seen > 0);
			7, 8: return status.state == game_state_e'(exp[1:0]);
			default: return 1'b1;
		endcase
	endfunction

	initial
	begin
		// id, keys, start, hold, limit, expected
		rows[0] = '{8'd1, 2'b00, 1'b0, 32'd2, 32'd1, 16'h01ff};
		rows[1] = '{8'd2, 2'b00, 1'b0, 32'd2, 32'd8000, 16'd3};
		rows[2] = '{8'd3, 2'b01, 1'b0, 32'd40, 32'd2000, 16'd540};
		rows[3] = '{8'd4, 2'b11, 1'b0, 32'd100, 32'd1, 16'd540};
		rows[4] = '{8'd5, 2'b10, 1'b0, 32'd40, 32'd2000, 16'd20};
		rows[5] = '{8'd6, 2'b00, 1'b0, 32'd2, 32'd900000, 16'd1};
		rows[6] = '{8'd7, 2'b00, 1'b1, 32'd2, 32'd100, 16'(st_play)};
		rows[7] = '{8'd8, 2'b00, 1'b0, 32'd100, 32'd20000, 16'(st_over)};

		clk = 1'b0;
		rst = 1'b0;
		start_game = 1'b0;
		keys = 2'b00;
		check_req = 1'b0;
		timed_out = 1'b0;
		test_id = 0;
		exp_val = '0;
		repeat (10) @(posedge clk);
		#1 rst = 1'b1;

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			@(posedge clk);
			#1;
			keys = rows[r].keys;
			start_game = rows[r].start;
			test_id = int'(rows[r].id);
			exp_val = rows[r].exp;
			cnt = 0;
			while (!cond_met(test_id, exp_val) && cnt < int'(rows[r].limit))
			begin
				@(posedge clk);
				cnt++;
			end
			timed_out = !cond_met(test_id, exp_val);
			repeat (rows[r].hold) @(posedge clk);
			#1 check_req = 1'b1;
			@(posedge clk);
			#1 check_req = 1'b0;
			timed_out = 1'b0;
		end

		repeat (2) @(posedge clk);
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			err_count);
		if (err_count == 0 && tests_failed == 0 && tests_run == NUM_ROWS)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Overall guard against a stuck sequence
	initial
	begin
		#20000000;
		$display("Simulation limit reached before the test sequence finished");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module tb_checker (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [1:0]                 keys,
	input  logic                       check_req,
	input  logic                       timed_out,
	input  int                         test_id,
	input  logic [15:0]                exp_val,
	input  breakout_pkg::vga_out_t     video,
	input  breakout_pkg::game_status_t status,
	input  breakout_pkg::vga_pos_t     pos,
	output int                         hs_periods,
	output int                         centre_seen,
	output int                         white_seen,
	output int                         err_count,
	output int                         tests_run,
	output int                         tests_failed
);
	import breakout_pkg::*;

	logic [23:0]  rgb;
	logic [1:0]   keys_prev;
	game_status_t prev;
	logic         hs_prev;
	logic         fall_seen;
	logic         first_move;
	longint       cyc;
	longint       last_fall;
	int           err_at_start;
	logic         pend;       // A pixel is waiting for its registered colour
	logic [23:0]  pend_rgb;
	logic         blank_pend; // Blank output due from the last pixel step
	logic         blank_exp;

	assign rgb = {video.red, video.green, video.blue};

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("mismatch in test %0d: %s got 0x%h expected 0x%h", test_id, name, got, exp);
		err_count++;
	endtask

	task automatic report_fail(input string msg);
		$display("test %0d: %s", test_id, msg);
		err_count++;
	endtask

	function automatic string test_name(input int id);
		case (id)
			1: return "reset values";
			2: return "video timing";
			3: return "paddle right";
			4: return "paddle hold";
			5: return "paddle left";
			6: return "colour rule";
			7: return "serve";
			default: return "bricks and end of game";
		endcase
	endfunction

	// End of row checks
	task automatic check_row();
		if (timed_out)
			report_fail("timed out waiting for the expected condition");
		case (test_id)
			1:
			begin
				if (status.state != st_idle && status.state != st_serve)
					report_fail("state is neither idle nor serve after reset");
				if (status.ball.x != 11'(`BALL_START_X))
					report_mismatch("ball.x", 32'(status.ball.x), `BALL_START_X);
				if (status.ball.y != 11'(`BALL_START_Y))
					report_mismatch("ball.y", 32'(status.ball.y), `BALL_START_Y);
				if (status.paddle_x != 11'(`PADDLE_START_X))
					report_mismatch("paddle_x", 32'(status.paddle_x), `PADDLE_START_X);
				if (status.mask != brick_mask_t'(exp_val))
					report_mismatch("mask", 32'(status.mask), 32'(exp_val));
				if (!video.hsync || !video.vsync)
					report_fail("sync outputs are not high after reset");
				if (rgb != 24'h0)
					report_mismatch("rgb", 32'(rgb), 32'h0);
			end
			2:
				if (hs_periods < int'(exp_val))
					report_fail("too few hsync periods were measured");
			3, 4, 5:
				if (status.paddle_x != exp_val[10:0])
					report_mismatch("paddle_x", 32'(status.paddle_x), 32'(exp_val));
			6:
				if (centre_seen == 0 || white_seen == 0)
					report_fail("ball centre or field pixel was never sampled");
			default:
			begin
				if (status.state != game_state_e'(exp_val[1:0]))
					report_mismatch("state", 32'(status.state), 32'(exp_val));
				if (test_id == 8 && status.mask == '1)
					report_fail("no brick was removed");
			end
		endcase
		tests_run++;
		if (err_count != err_at_start)
		begin
			tests_failed++;
			$display("test %0d %s: failed", test_id, test_name(test_id));
		end
		else
			$display("test %0d %s: ok", test_id, test_name(test_id));
		err_at_start = err_count;
	endtask

	initial
	begin
		hs_periods = 0;
		centre_seen = 0;
		white_seen = 0;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
		err_at_start = 0;
	end

	// Monitor runs on the falling edge
	always @(negedge clk)
	begin
		cyc++;
		if (!rst)
		begin
			prev <= status;
			keys_prev <= keys;
			hs_prev <= 1'b1;
			fall_seen <= 1'b0;
			first_move <= 1'b1;
			pend <= 1'b0;
			blank_pend <= 1'b0;
		end
		else
		begin
			if (!video.blank_n && rgb != 24'h0)
				report_mismatch("rgb", 32'(rgb), 32'h0);

			// Blank follows the 640x480 window one pixel later
			if (blank_pend && video.blank_n != blank_exp)
				report_mismatch("blank_n", 32'(video.blank_n), 32'(blank_exp));
			blank_pend <= pos.pix_en;
			blank_exp <= (pos.x < 11'(`H_ACTIVE)) && (pos.y < 11'(`V_ACTIVE));

			if (hs_prev && !video.hsync)
			begin
				if (fall_seen && cyc - last_fall != 64'd1588)
					report_mismatch("hsync period", 32'(cyc - last_fall), 32'd1588);
				else if (fall_seen)
					hs_periods++;
				fall_seen <= 1'b1;
				last_fall <= cyc;
			end
			if (!hs_prev && video.hsync && fall_seen && cyc - last_fall != 64'd184)
				report_mismatch("hsync width", 32'(cyc - last_fall), 32'd184);
			hs_prev <= video.hsync;

			if (status.paddle_x != prev.paddle_x)
			begin
				if (keys_prev == 2'b10 && status.paddle_x != prev.paddle_x - 1'b1)
					report_mismatch("paddle_x", 32'(status.paddle_x), 32'(prev.paddle_x - 1));
				else if (keys_prev == 2'b01 && status.paddle_x != prev.paddle_x + 1'b1)
					report_mismatch("paddle_x", 32'(status.paddle_x), 32'(prev.paddle_x + 1));
				else if (keys_prev != 2'b10 && keys_prev != 2'b01)
					report_mismatch("paddle_x", 32'(status.paddle_x), 32'(prev.paddle_x));
			end
			if (status.paddle_x < 20 || status.paddle_x > 540)
				report_fail("paddle left the playfield");

			if (status.ball != prev.ball)
			begin
				if (prev.state == st_over)
					report_fail("ball moved after the game ended");
				if (first_move && (status.ball.x != prev.ball.x - 1'b1
					|| status.ball.y != prev.ball.y - 1'b1))
					report_fail("first serve step is not up and to the left");
				else if ((status.ball.x != prev.ball.x + 1'b1 && status.ball.x != prev.ball.x - 1'b1)
					|| (status.ball.y != prev.ball.y + 1'b1 && status.ball.y != prev.ball.y - 1'b1))
					report_fail("ball step is not one pixel diagonal");
				first_move <= 1'b0;
			end

			if ((status.mask & ~prev.mask) != '0)
				report_mismatch("mask", 32'(status.mask), 32'(prev.mask));
			if (prev.state == st_over && status.state != st_over)
				report_mismatch("state", 32'(status.state), 32'(st_over));

			if (pend && rgb != pend_rgb)
				report_mismatch("rgb", 32'(rgb), 32'(pend_rgb));
			pend <= 1'b0;
			if (pos.pix_en && pos.active)
			begin
				// Ball centre below the bricks and above the paddle
				if (pos.x == status.ball.x + 11'd10 && pos.y == status.ball.y + 11'd10
					&& pos.y > 11'(`ROW1_Y + `BRICK_H) && pos.y < 11'(`PADDLE_Y))
				begin
					pend <= 1'b1;
					pend_rgb <= 24'h00ffff;
					centre_seen++;
				end
				else if (pos.x == 11'd320 && pos.y == 11'd300
					&& !(status.ball.x <= 320 && status.ball.x + 20 > 320
					&& status.ball.y <= 300 && status.ball.y + 20 > 300))
				begin
					pend <= 1'b1;
					pend_rgb <= 24'hffffff;
					white_seen++;
				end
			end

			prev <= status;
			keys_prev <= keys;
			if (check_req)
				check_row();
		end
	end

endmodule

`default_nettype wire

// ==== breakout_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module breakout_assertions #(
	parameter bit GAME_CHECKS = 1'b1
) (
	input logic                      clk,
	input logic                      rst,
	input breakout_pkg::game_state_e state,
	input logic                      ball_tick,
	input logic                      paddle_tick,
	input breakout_pkg::coord_t      h_cnt,
	input logic                      hsync
);
	import breakout_pkg::*;

	if (GAME_CHECKS)
	begin : g_game
		// Game over is terminal
		over_stays: assert property (@(posedge clk) disable iff (!rst)
			state == st_over |=> state == st_over)
			else $error("state left game over");

		ball_tick_width: assert property (@(posedge clk) disable iff (!rst)
			ball_tick |=> !ball_tick)
			else $error("ball tick wider than one cycle");

		paddle_tick_width: assert property (@(posedge clk) disable iff (!rst)
			paddle_tick |=> !paddle_tick)
			else $error("paddle tick wider than one cycle");
	end
	else
	begin : g_video
		// Sync lags the counter by one pixel
		hsync_window: assert property (@(posedge clk) disable iff (!rst)
			!hsync |-> (h_cnt >= `H_SYNC_START + 1) && (h_cnt <= `H_SYNC_END))
			else $error("hsync low outside its window");
	end

endmodule

bind game_control breakout_assertions #(.GAME_CHECKS(1'b1)) game_sva_i (
	.clk(clk), .rst(rst), .state(state), .ball_tick(ball_tick),
	.paddle_tick(paddle_tick), .h_cnt(11'd0), .hsync(1'b1)
);

bind vga_timing breakout_assertions #(.GAME_CHECKS(1'b0)) video_sva_i (
	.clk(clk), .rst(rst), .state(breakout_pkg::st_idle), .ball_tick(1'b0),
	.paddle_tick(1'b0), .h_cnt(h_cnt), .hsync(hsync)
);

`default_nettype wire

// ==== breakout_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module breakout_top #(
	parameter int BALL_DIV   = `DEF_BALL_DIV,
	parameter int PADDLE_DIV = `DEF_PADDLE_DIV
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start_game,
	input  logic [1:0]                 keys,
	output breakout_pkg::vga_out_t     video,
	output breakout_pkg::game_status_t status
);
	import breakout_pkg::*;

	logic        ball_tick;
	logic        paddle_tick;
	logic        clear_en;
	logic        brick_hit;
	logic        brick_px;
	logic        hsync;
	logic        vsync;
	logic        blank_n;
	ball_dir_e   ball_dir;
	game_state_e state;
	contact_t    contact;
	point_t      ball;
	coord_t      paddle_x;
	brick_mask_t mask;
	vga_pos_t    pos;

	game_control #(.BALL_DIV(BALL_DIV), .PADDLE_DIV(PADDLE_DIV)) control_i (
		.clk(clk), .rst(rst), .start_game(start_game), .contact(contact),
		.brick_hit(brick_hit), .ball_tick(ball_tick), .paddle_tick(paddle_tick),
		.clear_en(clear_en), .ball_dir(ball_dir), .state(state)
	);

	ball_motion ball_i (
		.clk(clk), .rst(rst), .ball_tick(ball_tick), .hold(state != st_play),
		.ball_dir(ball_dir), .paddle_x(paddle_x), .ball(ball), .contact(contact)
	);

	brick_wall bricks_i (
		.clk(clk), .rst(rst), .clear_en(clear_en), .ball(ball), .pos(pos),
		.mask(mask), .brick_hit(brick_hit), .brick_px(brick_px)
	);

	paddle_motion paddle_i (
		.clk(clk), .rst(rst), .paddle_tick(paddle_tick), .keys(keys), .paddle_x(paddle_x)
	);

	vga_timing timing_i (
		.clk(clk), .rst(rst), .pos(pos), .hsync(hsync), .vsync(vsync), .blank_n(blank_n)
	);

	pixel_mixer mixer_i (
		.clk(clk), .rst(rst), .pos(pos), .hsync(hsync), .vsync(vsync), .blank_n(blank_n),
		.ball(ball), .paddle_x(paddle_x), .brick_px(brick_px), .video(video)
	);

	assign status = '{state: state, ball: ball, paddle_x: paddle_x, mask: mask};

endmodule

`default_nettype wire

// ==== pixel_mixer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module pixel_mixer (
	input  logic                   clk,
	input  logic                   rst,
	input  breakout_pkg::vga_pos_t pos,
	input  logic                   hsync,
	input  logic                   vsync,
	input  logic                   blank_n,
	input  breakout_pkg::point_t   ball,
	input  breakout_pkg::coord_t   paddle_x,
	input  logic                   brick_px,
	output breakout_pkg::vga_out_t video
);
	logic        in_field;
	logic        paddle_px;
	logic        ball_px;
	logic [23:0] rgb; // Red, green, blue

	assign in_field = (pos.x >= `FIELD_LEFT) && (pos.x < `FIELD_RIGHT)
		&& (pos.y >= `FIELD_TOP) && (pos.y < `FIELD_BOTTOM);
	assign paddle_px = (pos.x >= paddle_x) && (pos.x < paddle_x + `PADDLE_W)
		&& (pos.y >= `PADDLE_Y) && (pos.y < `PADDLE_Y + `PADDLE_H);
	assign ball_px = (pos.x >= ball.x) && (pos.x < ball.x + `BALL_SIZE)
		&& (pos.y >= ball.y) && (pos.y < ball.y + `BALL_SIZE);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			rgb <= '0;
		else if (pos.pix_en)
		begin
			if (!pos.active || !in_field)
				rgb <= 24'h000000;
			else if (paddle_px)
				rgb <= 24'h0000ff;
			else if (brick_px)
				rgb <= 24'hffff00; // Yellow bricks
			else if (ball_px)
				rgb <= 24'h00ffff;
			else
				rgb <= 24'hffffff;
		end
	end

	assign video = '{hsync: hsync, vsync: vsync, blank_n: blank_n,
		red: rgb[23:16], green: rgb[15:8], blue: rgb[7:0]};

endmodule

`default_nettype wire

// ==== paddle_motion.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module paddle_motion (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 paddle_tick,
	input  logic [1:0]           keys,
	output breakout_pkg::coord_t paddle_x
);
	import breakout_pkg::*;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			paddle_x <= coord_t'(`PADDLE_START_X);
		else if (paddle_tick)
		begin
			case (keys)
				2'b10:
					if (paddle_x > `FIELD_LEFT)
						paddle_x <= paddle_x - 1'b1; // Left
				2'b01:
					if (paddle_x < `FIELD_RIGHT - `PADDLE_W)
						paddle_x <= paddle_x + 1'b1; // Right
				default:
					paddle_x <= paddle_x;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== brick_wall.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module brick_wall (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      clear_en,
	input  breakout_pkg::point_t      ball,
	input  breakout_pkg::vga_pos_t    pos,
	output breakout_pkg::brick_mask_t mask,
	output logic                      brick_hit,
	output logic                      brick_px
);
	import breakout_pkg::*;

	localparam int ROW0_N = (`NUM_BRICKS + 1) / 2; // Five on the top row

	brick_mask_t hit_vec;
	brick_mask_t cover_vec;

	for (genvar i = 0; i < `NUM_BRICKS; i++)
	begin : g_brick
		localparam coord_t BX = (i < ROW0_N) ? coord_t'(`ROW0_X + i * `BRICK_PITCH)
			: coord_t'(`ROW1_X + (i - ROW0_N) * `BRICK_PITCH);
		localparam coord_t BY = (i < ROW0_N) ? coord_t'(`ROW0_Y) : coord_t'(`ROW1_Y);

		// Ball rectangle overlaps this brick
		assign hit_vec[i] = mask[i]
			&& (ball.x + `BALL_SIZE >= BX) && (ball.x <= BX + `BRICK_W)
			&& (ball.y + `BALL_SIZE >= BY) && (ball.y <= BY + `BRICK_H);

		assign cover_vec[i] = mask[i]
			&& (pos.x >= BX) && (pos.x < BX + `BRICK_W)
			&& (pos.y >= BY) && (pos.y < BY + `BRICK_H);
	end

	assign brick_hit = |hit_vec;
	assign brick_px = pos.active && (|cover_vec);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			mask <= '1; // Full wall
		else if (clear_en)
			mask <= mask & ~hit_vec;
	end

endmodule

`default_nettype wire

// ==== ball_motion.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module ball_motion (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ball_tick,
	input  logic                    hold,
	input  breakout_pkg::ball_dir_e ball_dir,
	input  breakout_pkg::coord_t    paddle_x,
	output breakout_pkg::point_t    ball,
	output breakout_pkg::contact_t  contact
);
	import breakout_pkg::*;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			ball.x <= coord_t'(`BALL_START_X);
			ball.y <= coord_t'(`BALL_START_Y);
		end
		else if (ball_tick && !hold)
		begin
			ball.x <= (ball_dir == dir_ne || ball_dir == dir_se) ? ball.x + 1'b1 : ball.x - 1'b1;
			ball.y <= (ball_dir == dir_ne || ball_dir == dir_nw) ? ball.y - 1'b1 : ball.y + 1'b1;
		end
	end

	// Wall contacts include overshoot past the bound
	assign contact.hit_left = (ball.x <= `FIELD_LEFT);
	assign contact.hit_right = (ball.x + `BALL_SIZE >= `FIELD_RIGHT);
	assign contact.hit_top = (ball.y <= `FIELD_TOP);
	assign contact.hit_bottom = (ball.y >= `FIELD_BOTTOM);

	// Ball bottom edge within the paddle's depth and span
	assign contact.hit_paddle = (ball.y + `BALL_SIZE >= `PADDLE_Y)
		&& (ball.y + `BALL_SIZE <= `PADDLE_Y + `PADDLE_H)
		&& (ball.x + `BALL_SIZE >= paddle_x)
		&& (ball.x <= paddle_x + `PADDLE_W);

endmodule

`default_nettype wire

// ==== game_control.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module game_control #(
	parameter int BALL_DIV   = `DEF_BALL_DIV,
	parameter int PADDLE_DIV = `DEF_PADDLE_DIV
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start_game,
	input  breakout_pkg::contact_t   contact,
	input  logic                     brick_hit,
	output logic                     ball_tick,
	output logic                     paddle_tick,
	output logic                     clear_en,
	output breakout_pkg::ball_dir_e  ball_dir,
	output breakout_pkg::game_state_e state
);
	import breakout_pkg::*;

	localparam int CW = $clog2((BALL_DIV > PADDLE_DIV ? BALL_DIV : PADDLE_DIV) + 1);

	logic [1:0] tick;
	logic       north;
	ball_dir_e  next_dir;

	// Index 0 paces the ball, index 1 the paddle
	for (genvar i = 0; i < 2; i++)
	begin : g_tick
		localparam int DIV = (i == 0) ? BALL_DIV : PADDLE_DIV;
		logic [CW-1:0] cnt;
		logic          pulse;

		always_ff @(posedge clk or negedge rst)
		begin
			if (!rst)
			begin
				cnt <= '0;
				pulse <= 1'b0;
			end
			else if (cnt == CW'(DIV - 1))
			begin
				cnt <= '0;
				pulse <= 1'b1;
			end
			else
			begin
				cnt <= cnt + 1'b1;
				pulse <= 1'b0;
			end
		end

		assign tick[i] = pulse;
	end

	assign ball_tick = tick[0];
	assign paddle_tick = tick[1];

	assign north = (ball_dir == dir_ne) || (ball_dir == dir_nw);
	assign clear_en = ball_tick && (state == st_play) && north; // Bricks break only going up

	// Side walls win over every other contact
	always_comb
	begin
		next_dir = ball_dir;
		if (contact.hit_left)
			next_dir = north ? dir_ne : dir_se;
		else if (contact.hit_right)
			next_dir = north ? dir_nw : dir_sw;
		else if (north && (contact.hit_top || brick_hit))
			next_dir = (ball_dir == dir_ne) ? dir_se : dir_sw;
		else if (!north && contact.hit_paddle)
			next_dir = (ball_dir == dir_se) ? dir_ne : dir_nw;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= st_idle;
			ball_dir <= dir_nw;
		end
		else if (ball_tick)
		begin
			case (state)
				st_idle:
					state <= st_serve;
				st_serve:
					if (start_game)
					begin
						state <= st_play;
						ball_dir <= dir_nw; // Serve up and to the left
					end
				st_play:
					if (contact.hit_bottom)
						state <= st_over;
					else
						ball_dir <= next_dir;
				default:
					state <= st_over; // Terminal until reset
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "breakout_macros.svh"

module vga_timing (
	input  logic                  clk,
	input  logic                  rst,
	output breakout_pkg::vga_pos_t pos,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  blank_n
);
	import breakout_pkg::*;

	logic   pix_en;
	coord_t h_cnt;
	coord_t v_cnt;
	logic   active;

	assign active = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
	assign pos = '{x: h_cnt, y: v_cnt, active: active, pix_en: pix_en};

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pix_en <= 1'b0;
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else
		begin
			pix_en <= ~pix_en; // Half rate pixel enable
			if (pix_en)
			begin
				if (h_cnt == `H_MAX)
				begin
					h_cnt <= '0;
					v_cnt <= (v_cnt == `V_MAX) ? '0 : v_cnt + 1'b1;
				end
				else
					h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// Sync and blank lag the counters by one pixel
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank_n <= 1'b0;
		end
		else if (pix_en)
		begin
			hsync <= !((h_cnt >= `H_SYNC_START) && (h_cnt < `H_SYNC_END));
			vsync <= !((v_cnt >= `V_SYNC_START) && (v_cnt < `V_SYNC_END));
			blank_n <= active;
		end
	end

endmodule

`default_nettype wire

// ==== breakout_pkg.sv ====
`default_nettype none
`include "breakout_macros.svh"

package breakout_pkg;

	typedef logic [10:0] coord_t; // Screen coordinate

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	typedef enum logic [1:0] {
		dir_ne,
		dir_nw,
		dir_sw,
		dir_se
	} ball_dir_e;

	typedef enum logic [1:0] {
		st_idle,
		st_serve,
		st_play,
		st_over
	} game_state_e;

	typedef logic [`NUM_BRICKS-1:0] brick_mask_t; // One bit per present brick

	typedef struct packed {
		logic hit_left;
		logic hit_right;
		logic hit_top;
		logic hit_bottom;
		logic hit_paddle;
	} contact_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
		logic   pix_en;
	} vga_pos_t;

	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       blank_n;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} vga_out_t;

	typedef struct packed {
		game_state_e state;
		point_t      ball;
		coord_t      paddle_x;
		brick_mask_t mask;
	} game_status_t;

endpackage

`default_nettype wire

// ==== breakout_macros.svh ====
`ifndef BREAKOUT_MACROS_SVH
`define BREAKOUT_MACROS_SVH

// 640x480 at 25 MHz pixel rate
`define H_ACTIVE       640
`define H_SYNC_START   655
`define H_SYNC_END     747
`define H_MAX          793
`define V_ACTIVE       480
`define V_SYNC_START   490
`define V_SYNC_END     492
`define V_MAX          525

// Playfield bounds in pixels
`define FIELD_LEFT     20
`define FIELD_TOP      20
`define FIELD_RIGHT    620
`define FIELD_BOTTOM   500

`define BALL_SIZE      20
`define PADDLE_W       80
`define PADDLE_H       15
`define PADDLE_Y       445

// Two rows, five bricks on top and four staggered below
`define BRICK_W        80
`define BRICK_H        30
`define NUM_BRICKS     9
`define ROW0_Y         20
`define ROW1_Y         52
`define ROW0_X         116
`define ROW1_X         157
`define BRICK_PITCH    82

`define BALL_START_X   310
`define BALL_START_Y   424
`define PADDLE_START_X 280

// Default game speed in clk cycles per step
`define DEF_BALL_DIV   300000
`define DEF_PADDLE_DIV 200000

`endif
